// ==== rtl/isaPkg.sv ====
package isaPkg;

    typedef logic [13:0] instrWordT;   // opcode | ra | rb
    typedef logic [3:0]  fieldT;       // register index or immediate

    typedef enum logic [5:0] {
        OpNop  = 6'h00,
        OpCpy  = 6'h03,
        OpSwap = 6'h04,
        OpAdd  = 6'h20,
        OpSub  = 6'h21,
        OpAddc = 6'h22,
        OpSubc = 6'h23,
        OpNot  = 6'h28,
        OpAnd  = 6'h29,
        OpOr   = 6'h2A,
        OpXor  = 6'h2B,
        OpShll = 6'h2C,
        OpShrl = 6'h2D,
        OpShla = 6'h2E,
        OpShra = 6'h2F,
        OpRotl = 6'h30,
        OpRotr = 6'h31,
        OpRtlc = 6'h32,
        OpRtrc = 6'h33
    } opcodeT;

    //------------------------------------------------------------
    // field extraction and decode helpers
    //------------------------------------------------------------

    function automatic opcodeT opOf(instrWordT instr);
        return opcodeT'(instr[13:8]);  // unlisted codes fall to NOP handling
    endfunction

    function automatic fieldT raOf(instrWordT instr);
        return instr[7:4];
    endfunction

    function automatic fieldT rbOf(instrWordT instr);
        return instr[3:0];
    endfunction

    // every kept instruction except NOP writes ra
    function automatic logic writesRa(opcodeT op);
        case (op)
            OpCpy, OpSwap,
            OpAdd, OpSub, OpAddc, OpSubc,
            OpNot, OpAnd, OpOr, OpXor,
            OpShll, OpShrl, OpShla, OpShra,
            OpRotl, OpRotr, OpRtlc, OpRtrc: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

    function automatic logic usesImm(opcodeT op);
        return (op == OpAddc) || (op == OpSubc);  // rb is a 4-bit constant
    endfunction

endpackage

// ==== rtl/dataPkg.sv ====
package dataPkg;

    typedef logic [13:0] dataWordT;   // one machine word
    typedef logic [3:0]  flagsT;      // {C, N, V, Z}

    // bit positions inside flagsT in the order of status bits 11..8
    localparam int FlagZ = 0;
    localparam int FlagV = 1;
    localparam int FlagN = 2;
    localparam int FlagC = 3;

endpackage

// ==== rtl/shiftRotate.sv ====
`timescale 1ns/1ns

module shiftRotate
    import isaPkg::*;
    import dataPkg::*;
(
    input  dataWordT shiftIn,
    input  fieldT    shiftCount,
    input  opcodeT   execOp,
    input  logic     carryIn,
    output dataWordT shiftOut,
    output logic     carryOut
);

    fieldT       rotCount;
    logic [27:0] rotLeft, rotRight;
    logic [29:0] carryLeft, carryRight;
    logic        carryCountOk;

    //------------------------------------------------------------
    // rotates built from a doubled word with one rule per op
    //------------------------------------------------------------

    // 14 and 15 wrap to 0 and 1 on a 14-bit ring
    assign rotCount = (shiftCount >= 4'd14) ? shiftCount - 4'd14 : shiftCount;
    assign rotLeft  = {shiftIn, shiftIn} << rotCount;
    assign rotRight = {shiftIn, shiftIn} >> rotCount;

    // through carry is a 15-bit ring {C, word}
    assign carryLeft    = {carryIn, shiftIn, carryIn, shiftIn} << shiftCount;
    assign carryRight   = {carryIn, shiftIn, carryIn, shiftIn} >> shiftCount;
    assign carryCountOk = (shiftCount != 4'd0) && (shiftCount != 4'd15);

    always_comb begin
        shiftOut = shiftIn;
        carryOut = carryIn;
        case (execOp)
            OpShll, OpShla: begin
                shiftOut = shiftIn << shiftCount;  // 14+ drains to zero
            end
            OpShrl: begin
                shiftOut = shiftIn >> shiftCount;
            end
            OpShra: begin
                shiftOut = $signed(shiftIn) >>> shiftCount;  // 14+ is all sign
            end
            OpRotl: begin
                shiftOut = rotLeft[27:14];
            end
            OpRotr: begin
                shiftOut = rotRight[13:0];
            end
            OpRtlc: begin
                if (carryCountOk) begin
                    {carryOut, shiftOut} = carryLeft[29:15];
                end
            end
            OpRtrc: begin
                if (carryCountOk) begin
                    {carryOut, shiftOut} = carryRight[14:0];
                end
            end
            default: begin
                shiftOut = shiftIn;
            end
        endcase
    end

endmodule

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ns

module fetchUnit
    import isaPkg::*;
#(
    parameter int ProgAddrWidth = 14
) (
    input  logic                     Clock_pin,
    input  logic                     rst,
    input  instrWordT                progData,
    output logic [ProgAddrWidth-1:0] progAddr,
    output instrWordT                fetchInstr,
    output logic                     fetchValid
);

    // no branches left, so the counter only ever steps by one
    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            progAddr   <= '0;
            fetchValid <= 1'b0;
        end else begin
            progAddr   <= progAddr + ProgAddrWidth'(1);
            fetchValid <= 1'b1;  // one instruction per cycle
        end
    end

    always_ff @(posedge Clock_pin) begin
        fetchInstr <= progData;  // MC0 instruction register
    end

endmodule

// ==== rtl/pipeControl.sv ====
`timescale 1ns/1ns

module pipeControl
    import isaPkg::*;
    import dataPkg::*;
(
    input  logic      Clock_pin,
    input  logic      rst,
    input  instrWordT fetchInstr,
    input  logic      fetchValid,
    input  dataWordT  readDataA,
    input  dataWordT  readDataB,
    input  dataWordT  resultHigh,
    input  dataWordT  resultLow,
    input  flagsT     execFlags,
    output fieldT     readIdxA,
    output fieldT     readIdxB,
    output logic      writeEn,
    output fieldT     writeIdx,
    output dataWordT  writeData,
    output logic      writeEnB,
    output fieldT     writeIdxB,
    output dataWordT  writeDataB,
    output opcodeT    execOp,
    output dataWordT  operandA,
    output dataWordT  operandB,
    output fieldT     shiftCount,
    output logic      wbValid,
    output fieldT     wbReg,
    output dataWordT  wbData,
    output logic      wbSwap,
    output fieldT     wbRegB,
    output dataWordT  wbDataB,
    output flagsT     statusFlags
);

    instrWordT execInstr, wbInstr;
    logic      execValid, wbStageValid;
    opcodeT    readOp, execStageOp, wbOp;
    logic      execWritesHigh, execWritesLow;
    logic      fwdAHigh, fwdALow, fwdBHigh, fwdBLow;
    dataWordT  regA, regB;

    assign readOp      = opOf(fetchInstr);
    assign readIdxA    = raOf(fetchInstr);
    assign readIdxB    = rbOf(fetchInstr);
    assign execStageOp = opOf(execInstr);
    assign wbOp        = opOf(wbInstr);

    // what the instruction now in execute will write next cycle
    assign execWritesHigh = execValid && writesRa(execStageOp);
    assign execWritesLow  = execValid && (execStageOp == OpSwap);

    //------------------------------------------------------------
    // MC1 operand read, MC2/MC3 stage tracking
    //------------------------------------------------------------

    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            execValid    <= 1'b0;
            wbStageValid <= 1'b0;
            fwdAHigh     <= 1'b0;
            fwdALow      <= 1'b0;
            fwdBHigh     <= 1'b0;
            fwdBLow      <= 1'b0;
        end else begin
            execValid    <= fetchValid;
            wbStageValid <= execValid;
            fwdAHigh     <= execWritesHigh && (raOf(execInstr) == readIdxA);
            fwdALow      <= execWritesLow && (rbOf(execInstr) == readIdxA);
            fwdBHigh     <= !usesImm(readOp) && execWritesHigh
                            && (raOf(execInstr) == readIdxB);
            fwdBLow      <= !usesImm(readOp) && execWritesLow
                            && (rbOf(execInstr) == readIdxB);
        end
    end

    // register file already covers older results through write-through
    always_ff @(posedge Clock_pin) begin
        execInstr <= fetchInstr;
        wbInstr   <= execInstr;
        regA      <= readDataA;
        regB      <= usesImm(readOp) ? {10'b0, readIdxB} : readDataB;
    end

    // previous instruction's result lands in the ALU registers just in time
    assign operandA   = fwdAHigh ? resultHigh : (fwdALow ? resultLow : regA);
    assign operandB   = fwdBHigh ? resultHigh : (fwdBLow ? resultLow : regB);
    assign execOp     = execValid ? execStageOp : OpNop;
    assign shiftCount = rbOf(execInstr);

    //------------------------------------------------------------
    // MC3 writeback
    //------------------------------------------------------------

    assign writeEn    = wbStageValid && writesRa(wbOp);
    assign writeIdx   = raOf(wbInstr);
    assign writeData  = resultHigh;
    assign writeEnB   = wbStageValid && (wbOp == OpSwap) && (rbOf(wbInstr) != raOf(wbInstr));
    assign writeIdxB  = rbOf(wbInstr);
    assign writeDataB = resultLow;

    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            wbValid     <= 1'b0;
            wbSwap      <= 1'b0;
            statusFlags <= '0;
        end else begin
            wbValid <= writeEn;
            wbSwap  <= wbStageValid && (wbOp == OpSwap);
            if (wbStageValid) begin
                statusFlags <= execFlags;  // commit with the instruction
            end
        end
    end

    always_ff @(posedge Clock_pin) begin
        wbReg   <= writeIdx;
        wbData  <= writeData;
        wbRegB  <= writeIdxB;
        wbDataB <= writeDataB;
    end

    // first instruction out of reset needs three more edges to retire
    wbQuietAfterReset: assert property (@(posedge Clock_pin)
        ($past(rst, 1) || $past(rst, 2) || $past(rst, 3) || $past(rst, 4)) |-> !wbValid);

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns

module regFile
    import isaPkg::*;
    import dataPkg::*;
#(
    parameter int NumRegs = 16
) (
    input  logic     Clock_pin,
    input  logic     rst,
    input  fieldT    readIdxA,
    input  fieldT    readIdxB,
    input  logic     writeEn,
    input  fieldT    writeIdx,
    input  dataWordT writeData,
    input  logic     writeEnB,
    input  fieldT    writeIdxB,
    input  dataWordT writeDataB,
    output dataWordT readDataA,
    output dataWordT readDataB
);

    dataWordT regs [NumRegs];

    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (writeEn && (int'(writeIdx) < NumRegs)) begin
                regs[writeIdx] <= writeData;
            end
            if (writeEnB && (int'(writeIdxB) < NumRegs)) begin
                regs[writeIdxB] <= writeDataB;  // second half of SWAP
            end
        end
    end

    // write-through so a same-cycle write is seen by the read stage
    function automatic dataWordT readPort(fieldT idx);
        if (writeEn && (writeIdx == idx)) begin
            return writeData;
        end else if (writeEnB && (writeIdxB == idx)) begin
            return writeDataB;
        end else if (int'(idx) < NumRegs) begin
            return regs[idx];
        end
        return '0;  // unimplemented register
    endfunction

    always_comb begin
        readDataA = readPort(readIdxA);
        readDataB = readPort(readIdxB);
    end

    // control only enables port B for a SWAP with distinct registers
    singleWriterPerReg: assert property (@(posedge Clock_pin) disable iff (rst)
        !(writeEn && writeEnB && (writeIdx == writeIdxB)));

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/1ns

module aluCore
    import isaPkg::*;
    import dataPkg::*;
(
    input  logic     Clock_pin,
    input  logic     rst,
    input  opcodeT   execOp,
    input  dataWordT operandA,
    input  dataWordT operandB,
    input  fieldT    shiftCount,
    output dataWordT resultHigh,
    output dataWordT resultLow,
    output flagsT    execFlags
);

    logic        isSub;
    dataWordT    addB;
    logic [14:0] addSum;
    dataWordT    logicOut;
    dataWordT    shiftOut;
    logic        shiftCarry;
    dataWordT    highNext, lowNext;
    flagsT       flagsNext;

    shiftRotate shifter (
        .shiftIn    (operandA),
        .shiftCount (shiftCount),
        .execOp     (execOp),
        .carryIn    (execFlags[FlagC]),  // C left by the previous instruction
        .shiftOut   (shiftOut),
        .carryOut   (shiftCarry)
    );

    //------------------------------------------------------------
    // adder/subtractor doing a - b as a + ~b + 1
    //------------------------------------------------------------

    assign isSub  = (execOp == OpSub) || (execOp == OpSubc);
    assign addB   = isSub ? ~operandB : operandB;
    assign addSum = {1'b0, operandA} + {1'b0, addB} + {14'b0, isSub};

    always_comb begin
        case (execOp)
            OpAnd:   logicOut = operandA & operandB;
            OpOr:    logicOut = operandA | operandB;
            OpXor:   logicOut = operandA ^ operandB;
            default: logicOut = ~operandA;
        endcase
    end

    always_comb begin
        highNext  = operandA;
        lowNext   = '0;
        flagsNext = execFlags;  // most ops leave flags alone
        case (execOp)
            OpAdd, OpSub, OpAddc, OpSubc: begin
                highNext         = addSum[13:0];
                flagsNext[FlagC] = addSum[14] ^ isSub;  // borrow is inverted carry
                flagsNext[FlagV] = (operandA[13] == addB[13])
                                   && (addSum[13] != operandA[13]);
                flagsNext[FlagN] = addSum[13];
                flagsNext[FlagZ] = (addSum[13:0] == '0);
            end
            OpNot, OpAnd, OpOr, OpXor: begin
                highNext         = logicOut;
                flagsNext[FlagC] = 1'b0;
                flagsNext[FlagV] = 1'b0;
                flagsNext[FlagN] = logicOut[13];
                flagsNext[FlagZ] = (logicOut == '0);
            end
            OpShll, OpShrl, OpShla, OpShra, OpRotl, OpRotr: begin
                highNext = shiftOut;
            end
            OpRtlc, OpRtrc: begin
                highNext         = shiftOut;
                flagsNext[FlagC] = shiftCarry;
            end
            OpCpy: begin
                highNext = operandB;
            end
            OpSwap: begin
                highNext = operandB;  // goes to ra
                lowNext  = operandA;  // goes to rb
            end
            default: begin
                highNext = operandA;
            end
        endcase
    end

    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            execFlags <= '0;
        end else begin
            execFlags <= flagsNext;
        end
    end

    always_ff @(posedge Clock_pin) begin
        resultHigh <= highNext;
        resultLow  <= lowNext;
    end

endmodule

// ==== rtl/risc14Core.sv ====
`timescale 1ns/1ns

module risc14Core
    import isaPkg::*;
    import dataPkg::*;
#(
    parameter int ProgAddrWidth = 14,
    parameter int NumRegs       = 16
) (
    input  logic                     Clock_pin,
    input  logic                     rst,
    output logic [ProgAddrWidth-1:0] progAddr,
    input  instrWordT                progData,
    output logic                     wbValid,
    output fieldT                    wbReg,
    output dataWordT                 wbData,
    output logic                     wbSwap,
    output fieldT                    wbRegB,
    output dataWordT                 wbDataB,
    output flagsT                    statusFlags
);

    instrWordT fetchInstr;
    logic      fetchValid;
    fieldT     readIdxA, readIdxB, writeIdx, writeIdxB, shiftCount;
    dataWordT  readDataA, readDataB, writeData, writeDataB;
    logic      writeEn, writeEnB;
    opcodeT    execOp;
    dataWordT  operandA, operandB, resultHigh, resultLow;
    flagsT     execFlags;

    //------------------------------------------------------------
    // MC0 fetch
    //------------------------------------------------------------

    fetchUnit #(
        .ProgAddrWidth (ProgAddrWidth)
    ) fetch (
        .Clock_pin  (Clock_pin),
        .rst        (rst),
        .progData   (progData),
        .progAddr   (progAddr),
        .fetchInstr (fetchInstr),
        .fetchValid (fetchValid)
    );

    //------------------------------------------------------------
    // MC1 read/forward, MC3 writeback control
    //------------------------------------------------------------

    pipeControl control (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .fetchInstr  (fetchInstr),
        .fetchValid  (fetchValid),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .resultHigh  (resultHigh),
        .resultLow   (resultLow),
        .execFlags   (execFlags),
        .readIdxA    (readIdxA),
        .readIdxB    (readIdxB),
        .writeEn     (writeEn),
        .writeIdx    (writeIdx),
        .writeData   (writeData),
        .writeEnB    (writeEnB),
        .writeIdxB   (writeIdxB),
        .writeDataB  (writeDataB),
        .execOp      (execOp),
        .operandA    (operandA),
        .operandB    (operandB),
        .shiftCount  (shiftCount),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .wbSwap      (wbSwap),
        .wbRegB      (wbRegB),
        .wbDataB     (wbDataB),
        .statusFlags (statusFlags)
    );

    regFile #(
        .NumRegs (NumRegs)
    ) regs (
        .Clock_pin  (Clock_pin),
        .rst        (rst),
        .readIdxA   (readIdxA),
        .readIdxB   (readIdxB),
        .writeEn    (writeEn),
        .writeIdx   (writeIdx),
        .writeData  (writeData),
        .writeEnB   (writeEnB),
        .writeIdxB  (writeIdxB),
        .writeDataB (writeDataB),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

    // MC2 execute
    aluCore alu (
        .Clock_pin  (Clock_pin),
        .rst        (rst),
        .execOp     (execOp),
        .operandA   (operandA),
        .operandB   (operandB),
        .shiftCount (shiftCount),
        .resultHigh (resultHigh),
        .resultLow  (resultLow),
        .execFlags  (execFlags)
    );

endmodule

// ==== dv/risc14Tb.sv ====
`timescale 1ns/1ns

module risc14Tb
    import isaPkg::*;
    import dataPkg::*;
();

    localparam int MemDepth = 16384;  // whole 14-bit program space

    logic        Clock_pin = 1'b0;
    logic        rst = 1'b1;
    instrWordT   progData = '0;
    logic [13:0] progAddr;
    logic        wbValid;
    fieldT       wbReg;
    dataWordT    wbData;
    logic        wbSwap;
    fieldT       wbRegB;
    dataWordT    wbDataB;
    flagsT       statusFlags;

    instrWordT progMem [MemDepth];
    dataWordT  modelRegs [16];
    flagsT     modelFlags;
    int        progLen;
    int        cycleCount;
    int        seed = 94;

    // one entry per expected retirement, in program order
    fieldT    expReg [$];
    dataWordT expData [$];
    logic     expSwap [$];
    fieldT    expRegB [$];
    dataWordT expDataB [$];
    flagsT    expFlags [$];
    int       expAddr [$];

    string testName;
    int    testErrorStart;
    int    retiredCount;
    int    testsRun = 0;
    int    testsFailed = 0;
    int    checkCount = 0;
    int    errorCount = 0;

    opcodeT arithPool [4] = '{OpAdd, OpSub, OpAddc, OpSubc};
    opcodeT logicPool [6] = '{OpNot, OpAnd, OpOr, OpXor, OpCpy, OpSwap};
    opcodeT shiftPool [8] = '{OpShll, OpShrl, OpShla, OpShra,
                              OpRotl, OpRotr, OpRtlc, OpRtrc};
    opcodeT keptPool [18] = '{OpCpy, OpSwap, OpAdd, OpSub, OpAddc, OpSubc,
                              OpNot, OpAnd, OpOr, OpXor, OpShll, OpShrl,
                              OpShla, OpShra, OpRotl, OpRotr, OpRtlc, OpRtrc};
    logic [5:0] idleCodes [4] = '{6'h00, 6'h00, 6'h01, 6'h3E};  // NOP and unused codes

    risc14Core #(
        .ProgAddrWidth (14),
        .NumRegs       (16)
    ) dut (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .progAddr    (progAddr),
        .progData    (progData),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .wbSwap      (wbSwap),
        .wbRegB      (wbRegB),
        .wbDataB     (wbDataB),
        .statusFlags (statusFlags)
    );

    always #20 Clock_pin = ~Clock_pin;

    always @(negedge Clock_pin) begin
        progData <= progMem[progAddr];  // program answers every cycle
    end

    always @(posedge Clock_pin) begin
        if (rst) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;  // 1 after the first edge out of reset
        end
    end

    //------------------------------------------------------------
    // compare tasks
    //------------------------------------------------------------

    task automatic checkWord(string name, dataWordT exp, dataWordT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected 0x%h got 0x%h", $time, name, exp, act);
        end
    endtask

    task automatic checkReg(string name, fieldT exp, fieldT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected r%0d got r%0d", $time, name, exp, act);
        end
    endtask

    task automatic checkFlags(string name, flagsT exp, flagsT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected CNVZ=%b got CNVZ=%b",
                     $time, name, exp, act);
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkAddr(string name, logic [13:0] exp, logic [13:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkCycle(string name, int exp, int act);
        checkCount++;
        if (act != exp) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s expected cycle %0d got %0d", $time, name, exp, act);
        end
    endtask

    //------------------------------------------------------------
    // reference model and program builder
    //------------------------------------------------------------

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic fieldT randField();
        return fieldT'(randBelow(16));
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < MemDepth; i++) begin
            progMem[i] = '0;  // everything past the program is NOP
        end
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        modelFlags = '0;
        progLen = 0;
        expReg.delete();
        expData.delete();
        expSwap.delete();
        expRegB.delete();
        expDataB.delete();
        expFlags.delete();
        expAddr.delete();
    endtask

    task automatic addInstr(logic [5:0] code, fieldT ra, fieldT rb);
        dataWordT    a;
        dataWordT    b;
        dataWordT    r;
        dataWordT    rLow;
        flagsT       f;
        logic        c;
        logic [14:0] wide;
        int          n;
        logic        writes;
        logic        swaps;
        progMem[progLen] = {code, ra, rb};
        a = modelRegs[ra];
        b = (code == OpAddc || code == OpSubc) ? {10'b0, rb} : modelRegs[rb];
        f = modelFlags;
        r = a;
        rLow = '0;
        writes = 1'b1;
        swaps = 1'b0;
        case (code)
            OpAdd, OpAddc: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[13:0];
                f = {wide[14], r[13], (a[13] == b[13]) && (r[13] != a[13]), r == '0};
            end
            OpSub, OpSubc: begin
                r = a - b;
                f = {a < b, r[13], (a[13] != b[13]) && (r[13] != a[13]), r == '0};
            end
            OpNot, OpAnd, OpOr, OpXor: begin
                case (code)
                    OpAnd:   r = a & b;
                    OpOr:    r = a | b;
                    OpXor:   r = a ^ b;
                    default: r = ~a;
                endcase
                f = {1'b0, r[13], 1'b0, r == '0};
            end
            OpShll, OpShla: for (int k = 0; k < int'(rb); k++) r = {r[12:0], 1'b0};
            OpShrl: for (int k = 0; k < int'(rb); k++) r = {1'b0, r[13:1]};
            OpShra: for (int k = 0; k < int'(rb); k++) r = {r[13], r[13:1]};
            OpRotl, OpRotr: begin
                n = (rb >= 4'd14) ? int'(rb) - 14 : int'(rb);  // 14, 15 wrap to 0, 1
                for (int k = 0; k < n; k++) begin
                    r = (code == OpRotl) ? {r[12:0], r[13]} : {r[0], r[13:1]};
                end
            end
            OpRtlc, OpRtrc: begin
                c = f[3];
                if (rb >= 4'd1 && rb <= 4'd14) begin
                    for (int k = 0; k < int'(rb); k++) begin
                        if (code == OpRtlc) {c, r} = {r[13], r[12:0], c};
                        else {c, r} = {r[0], c, r[13:1]};
                    end
                end
                f[3] = c;  // 15-bit ring through carry
            end
            OpCpy: r = b;
            OpSwap: begin
                r = b;
                rLow = a;
                swaps = 1'b1;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            modelRegs[ra] = r;
            if (swaps) modelRegs[rb] = rLow;
            modelFlags = f;
            expReg.push_back(ra);
            expData.push_back(r);
            expSwap.push_back(swaps);
            expRegB.push_back(rb);
            expDataB.push_back(rLow);
            expFlags.push_back(f);
            expAddr.push_back(progLen);
        end
        progLen++;
    endtask

    // spread register values away from the all-zero reset state
    task automatic seedRegisters();
        for (int i = 0; i < 16; i++) begin
            addInstr(OpAddc, fieldT'(i), randField());
            addInstr(OpRotl, fieldT'(i), randField());
            addInstr(OpSubc, fieldT'(i), randField());
        end
    endtask

    function automatic opcodeT chainOp();
        case (randBelow(6))
            0, 1:    return OpRtlc;
            2, 3:    return OpRtrc;
            4:       return OpAdd;  // refreshes C for the chain
            default: return OpSub;
        endcase
    endfunction

    //------------------------------------------------------------
    // sequencing and retirement monitor
    //------------------------------------------------------------

    task automatic beginTest(string name);
        @(negedge Clock_pin);
        rst = 1'b1;
        @(posedge Clock_pin);
        clearProgram();
        testName = name;
        testErrorStart = errorCount;
        retiredCount = 0;
    endtask

    task automatic releaseReset();
        repeat (3) @(posedge Clock_pin);
        @(negedge Clock_pin);
        rst = 1'b0;
    endtask

    task automatic drainAndReport();
        int waited;
        int errs;
        waited = 0;
        while ((expReg.size() != 0 || cycleCount < progLen + 6) && waited < progLen + 40) begin
            @(negedge Clock_pin);
            waited++;
        end
        if (expReg.size() != 0) begin
            errorCount++;
            $display("test %s timed out with %0d writebacks never seen", testName, expReg.size());
        end
        errs = errorCount - testErrorStart;
        testsRun++;
        if (errs != 0) testsFailed++;
        $display("test %s done: %0d retired, %0d errors", testName, retiredCount, errs);
    endtask

    task automatic compareRetire();
        logic     swapExp;
        fieldT    regB;
        dataWordT dataB;
        checkReg("wbReg", expReg.pop_front(), wbReg);
        checkWord("wbData", expData.pop_front(), wbData);
        swapExp = expSwap.pop_front();
        regB = expRegB.pop_front();
        dataB = expDataB.pop_front();
        checkBit("wbSwap", swapExp, wbSwap);
        if (swapExp) begin
            checkReg("wbRegB", regB, wbRegB);
            checkWord("wbDataB", dataB, wbDataB);
        end
        checkFlags("statusFlags", expFlags.pop_front(), statusFlags);
        checkCycle("retire edge", expAddr.pop_front() + 4, cycleCount);  // fetch edge + 3
        retiredCount++;
    endtask

    always @(negedge Clock_pin) begin
        if (wbValid === 1'b1) begin
            if (expReg.size() == 0) begin
                errorCount++;
                $display("writeback to r%0d at %0t ns when no instruction was pending",
                         wbReg, $time);
            end else begin
                compareRetire();
            end
        end
    end

    initial begin
        clearProgram();

        beginTest("resetAndFetch");
        @(negedge Clock_pin);
        checkAddr("progAddr", '0, progAddr);
        releaseReset();
        for (int i = 1; i <= 12; i++) begin
            @(negedge Clock_pin);
            checkAddr("progAddr", 14'(i), progAddr);
        end
        drainAndReport();

        beginTest("addSub");
        seedRegisters();
        for (int i = 0; i < 64; i++) addInstr(arithPool[randBelow(4)], randField(), randField());
        releaseReset();
        drainAndReport();

        beginTest("logicCopySwap");
        seedRegisters();
        for (int i = 0; i < 64; i++) addInstr(logicPool[randBelow(6)], randField(), randField());
        releaseReset();
        drainAndReport();

        beginTest("shiftRotate");
        seedRegisters();
        foreach (shiftPool[k]) begin
            for (int cnt = 0; cnt < 16; cnt++) addInstr(shiftPool[k], randField(), fieldT'(cnt));
        end
        for (int i = 0; i < 48; i++) addInstr(chainOp(), 4'd5, randField());
        releaseReset();
        drainAndReport();

        // three registers only, so nearly every operand is forwarded
        beginTest("forwarding");
        seedRegisters();
        for (int i = 0; i < 160; i++) begin
            addInstr(keptPool[randBelow(18)], fieldT'(randBelow(3)), fieldT'(randBelow(3)));
        end
        releaseReset();
        drainAndReport();

        beginTest("nopMix");
        seedRegisters();
        for (int i = 0; i < 120; i++) begin
            if (randBelow(10) < 4) addInstr(idleCodes[randBelow(4)], randField(), randField());
            else addInstr(keptPool[randBelow(18)], randField(), randField());
        end
        releaseReset();
        drainAndReport();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== risc14.f ====
rtl/isaPkg.sv
rtl/dataPkg.sv
rtl/shiftRotate.sv
rtl/fetchUnit.sv
rtl/pipeControl.sv
rtl/regFile.sv
rtl/aluCore.sv
rtl/risc14Core.sv
dv/risc14Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the risc14 testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f risc14.f --top-module risc14Tb \
    -o risc14Sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/risc14Sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
